/* Makefile */
# Verilator build for the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= Result: PASSED

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST))) icache_defs.svh

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_TEXT)"; then \
		exit 0; \
	else \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)

/* icacheArray.sv */
// Instruction cache storage array

`timescale 1ns/1ps
`include "icache_defs.svh"

module icacheArray (
    input  logic                clk,
    input  logic                rst,
    input  logic                lookupEn,
    input  logic                refillEn,
    input  icachePkg::blockAddr_t blockAddr,
    input  icachePkg::block_t   refillData,
    output logic                hit,
    output icachePkg::block_t   readBlock
);
    import icachePkg::*;

    // column storage with one entry per set and way
    logic [`IC_WAYS-1:0]     validCol  [`IC_SETS];
    logic [`IC_WAYS-1:0]     statusCol [`IC_SETS];
    logic [`IC_TAG_BITS-1:0] tagCol    [`IC_SETS][`IC_WAYS];
    block_t                  dataCol   [`IC_SETS][`IC_WAYS];

    logic [`IC_INDEX_BITS-1:0] index;
    logic [`IC_TAG_BITS-1:0]   tag;

    wayMask_t hitWays;
    wayMask_t freeWays;
    wayMask_t victim;
    wayMask_t touched;
    wayMask_t setStatus;
    wayMask_t nextStatus;

    // blockAddr is {tag, index}
    assign index = blockAddr[`IC_INDEX_BITS-1:0];
    assign tag   = blockAddr[`IC_BLOCK_ADDR_BITS-1:`IC_INDEX_BITS];

    // compare every way of the indexed set
    always_comb begin
        for (int w = 0; w < `IC_WAYS; w++) begin
            hitWays[w] = validCol[index][w] && (tagCol[index][w] == tag);
        end
    end

    assign hit = |hitWays;

    // at most one way hits, so an OR of the selected lines is a mux
    always_comb begin
        readBlock = '0;
        for (int w = 0; w < `IC_WAYS; w++) begin
            if (hitWays[w]) begin
                readBlock = readBlock | dataCol[index][w];
            end
        end
    end

    // candidates are invalid ways or ways not recently used
    assign freeWays = ~(validCol[index] & statusCol[index]);

    // keep only the lowest candidate
    assign victim = freeWays & (~freeWays + wayMask_t'(1));

    // way touched by this cycle's access
    assign touched   = refillEn ? victim : hitWays;
    assign setStatus = statusCol[index] | touched;

    // a full set keeps only the newest bit
    assign nextStatus = (&setStatus) ? touched : setStatus;

    // valid, status and tag columns
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < `IC_SETS; s++) begin
                validCol[s]  <= '0;
                statusCol[s] <= '0;
                for (int w = 0; w < `IC_WAYS; w++) begin
                    tagCol[s][w] <= '0;
                end
            end
        end else if (refillEn) begin
            validCol[index]  <= validCol[index] | victim;
            statusCol[index] <= nextStatus;
            for (int w = 0; w < `IC_WAYS; w++) begin
                if (victim[w]) begin
                    tagCol[index][w] <= tag;
                end
            end
        end else if (lookupEn && hit) begin
            statusCol[index] <= nextStatus;
        end
    end

    // line data is written only on refill
    always_ff @(posedge clk) begin
        if (refillEn) begin
            for (int w = 0; w < `IC_WAYS; w++) begin
                if (victim[w]) begin
                    dataCol[index][w] <= refillData;
                end
            end
        end
    end

    // the controller never looks up and refills in the same cycle
    assert property (@(posedge clk) disable iff (!rst)
        !(lookupEn && refillEn))
        else $error("lookup and refill active together");

    // tags within a set stay unique across refills
    assert property (@(posedge clk) disable iff (!rst)
        lookupEn |-> $onehot0(hitWays))
        else $error("more than one way hit");

    // status rule must always leave a way to replace
    assert property (@(posedge clk) disable iff (!rst)
        refillEn |-> $onehot(victim))
        else $error("refill without a single victim");

endmodule

/* icacheController.sv */
// Instruction cache controller

`timescale 1ns/1ps
`include "icache_defs.svh"

module icacheController (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  reqValid,
    input  logic [`IC_ADDR_BITS-1:0] reqAddr,
    input  logic                  hit,
    input  icachePkg::block_t     readBlock,
    input  logic                  memValid,
    input  icachePkg::block_t     memData,
    output logic                  respValid,
    output icachePkg::word_t      respData,
    output logic                  memReq,
    output icachePkg::blockAddr_t memBlockAddr,
    output logic                  lookupEn,
    output logic                  refillEn,
    output icachePkg::blockAddr_t blockAddr,
    output icachePkg::block_t     refillData
);
    import icachePkg::*;

    localparam int LoBit = `IC_OFFSET_BITS + `IC_BYTE_BITS;

    ctrlState_t state;
    ctrlState_t nextState;

    logic [`IC_OFFSET_BITS-1:0] wordOff;
    logic                       missSeen;

    // split the fetch address
    assign blockAddr = reqAddr[`IC_ADDR_BITS-1:LoBit];
    assign wordOff   = reqAddr[LoBit-1:`IC_BYTE_BITS];

    // request is still held while its response pulses, so skip that cycle
    assign lookupEn = (state == stLookup) && reqValid && !respValid;
    assign missSeen = lookupEn && !hit;

    // refill straight from the memory bus
    assign refillEn   = (state == stRefill) && memValid;
    assign refillData = memData;

    always_comb begin
        nextState = state;
        unique case (state)
            stLookup: begin
                if (missSeen) begin
                    nextState = stMissReq;
                end
            end
            stMissReq: begin
                nextState = stRefill;
            end
            stRefill: begin
                if (memValid) begin
                    nextState = stLookup;
                end
            end
            default: begin
                nextState = stLookup;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state     <= stLookup;
            respValid <= 1'b0;
            memReq    <= 1'b0;
        end else begin
            state     <= nextState;
            respValid <= lookupEn && hit;
            // high for the single stMissReq cycle
            memReq    <= missSeen;
        end
    end

    // response word and request address
    always_ff @(posedge clk) begin
        if (lookupEn && hit) begin
            respData <= readBlock[wordOff * `IC_WORD_BITS +: `IC_WORD_BITS];
        end
        if (missSeen) begin
            memBlockAddr <= blockAddr;
        end
    end

    assert property (@(posedge clk) disable iff (!rst)
        memReq |-> (state == stMissReq))
        else $error("memReq outside stMissReq");

    // no new lookup starts during the response cycle
    assert property (@(posedge clk) disable iff (!rst)
        respValid |=> !respValid)
        else $error("respValid high in consecutive cycles");

endmodule

/* icachePkg.sv */
// Instruction cache types

`include "icache_defs.svh"

package icachePkg;

    // one fetched instruction
    typedef logic [`IC_WORD_BITS-1:0] word_t;

    // one full cache line, word 0 in the low bits
    typedef logic [`IC_BLOCK_BITS-1:0] block_t;

    // tag and set index of a line
    typedef logic [`IC_BLOCK_ADDR_BITS-1:0] blockAddr_t;

    // one bit per way
    typedef logic [`IC_WAYS-1:0] wayMask_t;

    // controller states
    typedef enum logic [1:0] {
        stLookup,
        stMissReq,
        stRefill
    } ctrlState_t;

endpackage

/* icacheTop.sv */
// Instruction cache top level

`timescale 1ns/1ps
`include "icache_defs.svh"

module icacheTop (
    input  logic                  clk,
    input  logic                  rst,
    // CPU fetch side
    input  logic                  reqValid,
    input  logic [`IC_ADDR_BITS-1:0] reqAddr,
    output logic                  respValid,
    output icachePkg::word_t      respData,
    // instruction memory side
    output logic                  memReq,
    output icachePkg::blockAddr_t memBlockAddr,
    input  logic                  memValid,
    input  icachePkg::block_t     memData
);
    import icachePkg::*;

    // controller to array
    logic       lookupEn;
    logic       refillEn;
    blockAddr_t blockAddr;
    block_t     refillData;

    // array to controller
    logic       hit;
    block_t     readBlock;

    icacheController uCtrl (
        .clk          (clk),
        .rst          (rst),
        .reqValid     (reqValid),
        .reqAddr      (reqAddr),
        .hit          (hit),
        .readBlock    (readBlock),
        .memValid     (memValid),
        .memData      (memData),
        .respValid    (respValid),
        .respData     (respData),
        .memReq       (memReq),
        .memBlockAddr (memBlockAddr),
        .lookupEn     (lookupEn),
        .refillEn     (refillEn),
        .blockAddr    (blockAddr),
        .refillData   (refillData)
    );

    icacheArray uArray (
        .clk        (clk),
        .rst        (rst),
        .lookupEn   (lookupEn),
        .refillEn   (refillEn),
        .blockAddr  (blockAddr),
        .refillData (refillData),
        .hit        (hit),
        .readBlock  (readBlock)
    );

endmodule

/* icache_defs.svh */
// Instruction cache geometry

`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// fetch address and instruction width
`define IC_ADDR_BITS 32
`define IC_WORD_BITS 32

// block layout
`define IC_WORDS_PER_BLOCK 4
`define IC_BLOCK_BITS (`IC_WORDS_PER_BLOCK * `IC_WORD_BITS)

// organisation
`define IC_SETS 16
`define IC_WAYS 4

// low address fields in order byte, word offset and index
`define IC_BYTE_BITS 2
`define IC_OFFSET_BITS 2
`define IC_INDEX_BITS 4

// tag takes whatever is left of the address
`define IC_TAG_BITS \
    (`IC_ADDR_BITS - `IC_INDEX_BITS - `IC_OFFSET_BITS - `IC_BYTE_BITS)

// block address is {tag, index}
`define IC_BLOCK_ADDR_BITS (`IC_TAG_BITS + `IC_INDEX_BITS)

`endif

/* src.f */
+incdir+.
icachePkg.sv
icacheArray.sv
icacheController.sv
icacheTop.sv
tb_icache.sv

/* tb_icache.sv */
// Instruction cache testbench

`timescale 1ns/1ps
`include "icache_defs.svh"

module tb_icache;
    import icachePkg::*;

    localparam int ClkPeriod = 8;
    localparam int LoBit = `IC_OFFSET_BITS + `IC_BYTE_BITS;
    // worst fetch is a miss with the longest memory latency
    localparam int CyclesPerEntry = 8 + 6;
    localparam int MarginCycles = 40;

    logic                     clk;
    logic                     rst;
    logic                     reqValid;
    logic [`IC_ADDR_BITS-1:0] reqAddr;
    logic                     respValid;
    word_t                    respData;
    logic                     memReq;
    blockAddr_t               memBlockAddr;
    logic                     memValid;
    block_t                   memData;

    // stimulus table with one fetch per entry
    logic [`IC_ADDR_BITS-1:0] tableAddr [$];
    logic                     tableMiss [$];
    logic                     tableReady = 1'b0;

    // reference copy of the cache state
    logic [`IC_WAYS-1:0]     refValid  [`IC_SETS];
    logic [`IC_WAYS-1:0]     refStatus [`IC_SETS];
    logic [`IC_TAG_BITS-1:0] refTag    [`IC_SETS][`IC_WAYS];

    logic [31:0] lfsrState = 32'h4124ee64;

    icacheTop u_dut (
        .clk          (clk),
        .rst          (rst),
        .reqValid     (reqValid),
        .reqAddr      (reqAddr),
        .respValid    (respValid),
        .respData     (respData),
        .memReq       (memReq),
        .memBlockAddr (memBlockAddr),
        .memValid     (memValid),
        .memData      (memData)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic logic lfsrStep();
        logic fb;
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    function automatic int randomBits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsrStep());
        end
        return v;
    endfunction

    // memory content where an odd multiply keeps every word address distinct
    function automatic word_t mixWord(input blockAddr_t b, input int w);
        logic [`IC_OFFSET_BITS-1:0] wo;
        logic [31:0]                key;
        wo  = w[`IC_OFFSET_BITS-1:0];
        key = 32'({b, wo});
        return word_t'((key * 32'h9E3779B1) ^ 32'hC3A50F1E);
    endfunction

    function automatic block_t makeBlock(input blockAddr_t b);
        block_t blk;
        for (int w = 0; w < `IC_WORDS_PER_BLOCK; w++) begin
            blk[w * `IC_WORD_BITS +: `IC_WORD_BITS] = mixWord(b, w);
        end
        return blk;
    endfunction

    function automatic logic [`IC_ADDR_BITS-1:0] mkAddr(
        input logic [`IC_TAG_BITS-1:0]    tag,
        input logic [`IC_INDEX_BITS-1:0]  idx,
        input logic [`IC_OFFSET_BITS-1:0] off
    );
        logic [`IC_BYTE_BITS-1:0] zeroByte;
        zeroByte = '0;
        return {tag, idx, off, zeroByte};
    endfunction

    // apply one fetch to the model and return 1 on a miss
    function automatic logic modelAccess(input logic [`IC_ADDR_BITS-1:0] addr);
        logic [`IC_INDEX_BITS-1:0] setIdx;
        logic [`IC_TAG_BITS-1:0]   tag;
        logic [`IC_WAYS-1:0]       onehot;
        logic                      miss;
        setIdx = addr[`IC_INDEX_BITS+LoBit-1:LoBit];
        tag    = addr[`IC_ADDR_BITS-1:`IC_INDEX_BITS+LoBit];
        onehot = '0;
        for (int w = 0; w < `IC_WAYS; w++) begin
            if (refValid[setIdx][w] && refTag[setIdx][w] == tag) begin
                onehot[w] = 1'b1;
            end
        end
        miss = (onehot == '0);
        if (miss) begin
            // walk down so the lowest candidate wins
            for (int w = `IC_WAYS - 1; w >= 0; w--) begin
                if (!refValid[setIdx][w] || !refStatus[setIdx][w]) begin
                    onehot    = '0;
                    onehot[w] = 1'b1;
                end
            end
            for (int w = 0; w < `IC_WAYS; w++) begin
                if (onehot[w]) begin
                    refValid[setIdx][w] = 1'b1;
                    refTag[setIdx][w]   = tag;
                end
            end
        end
        refStatus[setIdx] = refStatus[setIdx] | onehot;
        if (&refStatus[setIdx]) begin
            refStatus[setIdx] = onehot;
        end
        return miss;
    endfunction

    function automatic string ctrlName();
        ctrlState_t st;
        st = u_dut.uCtrl.state;
        return st.name();
    endfunction

    task automatic stopOnError();
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compareWord(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s, expected %h, got %h, controller in %s",
                     $time, what, expected, actual, ctrlName());
            stopOnError();
        end
    endtask

    task automatic compareBlockAddr(input blockAddr_t actual, input blockAddr_t expected,
                                    input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s, expected %h, got %h, controller in %s",
                     $time, what, expected, actual, ctrlName());
            stopOnError();
        end
    endtask

    task automatic compareFlag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s, expected %b, got %b, controller in %s",
                     $time, what, expected, actual, ctrlName());
            stopOnError();
        end
    endtask

    task automatic compareCount(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("Mismatch at %0t ns: %s, expected %0d, got %0d, controller in %s",
                     $time, what, expected, actual, ctrlName());
            stopOnError();
        end
    endtask

    task automatic addEntry(input logic [`IC_ADDR_BITS-1:0] addr, input logic miss);
        tableAddr.push_back(addr);
        tableMiss.push_back(miss);
    endtask

    task automatic buildTable();
        // cold miss and then hits at other word offsets
        addEntry(mkAddr(24'h000010, 4'd3, 2'd0), 1'b1);
        addEntry(mkAddr(24'h000010, 4'd3, 2'd2), 1'b0);
        addEntry(mkAddr(24'h000010, 4'd3, 2'd3), 1'b0);
        // fill the other three ways of set 3
        addEntry(mkAddr(24'h000020, 4'd3, 2'd1), 1'b1);
        addEntry(mkAddr(24'h000030, 4'd3, 2'd0), 1'b1);
        addEntry(mkAddr(24'h000040, 4'd3, 2'd3), 1'b1);
        addEntry(mkAddr(24'h000010, 4'd3, 2'd1), 1'b0);
        addEntry(mkAddr(24'h000020, 4'd3, 2'd2), 1'b0);
        addEntry(mkAddr(24'h000030, 4'd3, 2'd3), 1'b0);
        addEntry(mkAddr(24'h000040, 4'd3, 2'd0), 1'b0);
        // fifth tag takes way 0 and the evicted tag then misses into way 1
        addEntry(mkAddr(24'h000050, 4'd3, 2'd1), 1'b1);
        addEntry(mkAddr(24'h000010, 4'd3, 2'd0), 1'b1);
        addEntry(mkAddr(24'h000030, 4'd3, 2'd1), 1'b0);
        addEntry(mkAddr(24'h000040, 4'd3, 2'd2), 1'b0);
        addEntry(mkAddr(24'h000050, 4'd3, 2'd3), 1'b0);
        // set 5 interleaved with set 3
        addEntry(mkAddr(24'h000010, 4'd5, 2'd2), 1'b1);
        addEntry(mkAddr(24'h000010, 4'd3, 2'd3), 1'b0);
        addEntry(mkAddr(24'h000010, 4'd5, 2'd0), 1'b0);
        addEntry(mkAddr(24'h000777, 4'd5, 2'd1), 1'b1);
        addEntry(mkAddr(24'h000050, 4'd3, 2'd2), 1'b0);
        addEntry(mkAddr(24'h000777, 4'd5, 2'd3), 1'b0);
        addEntry(mkAddr(24'h000020, 4'd3, 2'd0), 1'b1);
        addEntry(mkAddr(24'h000030, 4'd3, 2'd2), 1'b1);
        addEntry(mkAddr(24'h000010, 4'd5, 2'd1), 1'b0);
        addEntry(mkAddr(24'h000040, 4'd3, 2'd1), 1'b1);
        // top of the address space
        addEntry(mkAddr(24'hFFFFFF, 4'd15, 2'd3), 1'b1);
        addEntry(mkAddr(24'hFFFFFF, 4'd15, 2'd0), 1'b0);
    endtask

    task automatic runEntry(input int i);
        logic [`IC_ADDR_BITS-1:0] addr;
        blockAddr_t               expBlock;
        word_t                    expWord;
        logic                     modelMiss;
        int                       cycles;
        int                       memReqs;
        logic                     done;
        addr      = tableAddr[i];
        expBlock  = addr[`IC_ADDR_BITS-1:LoBit];
        expWord   = mixWord(expBlock, int'(addr[LoBit-1:`IC_BYTE_BITS]));
        modelMiss = modelAccess(addr);
        compareFlag(modelMiss, tableMiss[i], $sformatf("table miss flag, entry %0d", i));
        reqValid <= 1'b1;
        reqAddr  <= addr;
        cycles  = 0;
        memReqs = 0;
        done    = 1'b0;
        while (!done) begin
            @(posedge clk);
            cycles++;
            if (memReq) begin
                memReqs++;
                compareBlockAddr(memBlockAddr, expBlock,
                                 $sformatf("memory request address, entry %0d", i));
            end
            if (respValid) begin
                done = 1'b1;
            end
        end
        compareFlag(memReqs > 0, tableMiss[i], $sformatf("miss seen, entry %0d", i));
        compareCount(memReqs, tableMiss[i] ? 1 : 0, $sformatf("memory requests, entry %0d", i));
        compareWord(respData, expWord, $sformatf("response word, entry %0d", i));
        if (!tableMiss[i]) begin
            // sampled at the first edge with respValid high before the second
            compareCount(cycles, 2, $sformatf("hit latency, entry %0d", i));
        end
    endtask

    // instruction memory with random latency of 1 to 8 cycles
    initial begin
        blockAddr_t reqBlock;
        int         latency;
        memValid <= 1'b0;
        memData  <= '0;
        forever begin
            @(posedge clk);
            if (memReq) begin
                reqBlock = memBlockAddr;
                latency  = 1 + randomBits(3);
                repeat (latency) @(posedge clk);
                memValid <= 1'b1;
                memData  <= makeBlock(reqBlock);
                @(posedge clk);
                memValid <= 1'b0;
            end
        end
    end

    initial begin
        rst      <= 1'b0;
        reqValid <= 1'b0;
        reqAddr  <= '0;
        for (int s = 0; s < `IC_SETS; s++) begin
            refValid[s]  = '0;
            refStatus[s] = '0;
            for (int w = 0; w < `IC_WAYS; w++) begin
                refTag[s][w] = '0;
            end
        end
        buildTable();
        tableReady = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < tableAddr.size(); i++) begin
            runEntry(i);
        end
        reqValid <= 1'b0;
        // idle bus must stay quiet
        repeat (4) begin
            @(posedge clk);
            compareFlag(memReq, 1'b0, "memReq while idle");
            compareFlag(respValid, 1'b0, "respValid while idle");
        end
        $display("Result: PASSED");
        $finish;
    end

    initial begin
        int limitNs;
        wait (tableReady);
        limitNs = (tableAddr.size() * CyclesPerEntry + MarginCycles) * ClkPeriod;
        #(limitNs);
        $display("Watchdog expired after %0d ns, the cache stopped responding", limitNs);
        $display("Result: FAILED");
        $fatal(1, "timeout");
    end

endmodule
